// File: fifo_ctl_pkg.sv
// Single clock only; depth code 7 tracks at most 4095 bytes because pointers carry 12 bits.
`default_nettype none

package fifo_ctl_pkg;

	// ====================
	// Widths
	// ====================

	// Byte address into the storage RAM.
	localparam int ADDR_WIDTH = 11;

	// One extra bit tells a full FIFO from an empty one.
	localparam int PTR_WIDTH = ADDR_WIDTH + 1;

	// Largest capacity, selected by depth code 7.
	localparam logic [PTR_WIDTH:0] MAX_CAPACITY = {1'b1, {PTR_WIDTH{1'b0}}};

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [PTR_WIDTH-1:0] ptr_t;
	typedef logic [2:0] depth_code_t;

	// ====================
	// Configuration
	// ====================

	// Port width, shared by the push and pop sides.
	typedef enum logic [1:0] {
		W32 = 2'd0,
		W16 = 2'd1,
		W8  = 2'd2,
		OFF = 2'd3
	} width_mode_t;

	// Thresholds count words of the selected width.
	typedef struct packed {
		depth_code_t depth;
		width_mode_t width;
		addr_t       upaf;
		addr_t       upae;
	} fifo_cfg_t;

	// ====================
	// Status flags
	// ====================

	typedef struct packed {
		logic full;
		logic fmo;
		logic paf;
		logic overflow;
	} push_flags_t;

	typedef struct packed {
		logic empty;
		logic epo;
		logic pae;
		logic underflow;
	} pop_flags_t;

	// ====================
	// Decode helpers
	// ====================

	// Codes 0 to 6 halve from 2048 down to 32 bytes.
	function automatic logic [PTR_WIDTH:0] capacity_bytes(input depth_code_t code);
		logic [3:0] shift;
		shift = {1'b0, code} + 4'd1;
		if (code == 3'd7) begin
			return MAX_CAPACITY;
		end
		return MAX_CAPACITY >> shift;
	endfunction

	// Bytes moved by one access; zero when disabled.
	function automatic logic [2:0] step_bytes(input width_mode_t mode);
		case (mode)
			W32:     return 3'd4;
			W16:     return 3'd2;
			W8:      return 3'd1;
			default: return 3'd0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: fifo_push_ctl.sv
// Push side; cfg may change only in reset, and rptr must be the pop-side register output.
`timescale 1ns/1ps
`default_nettype none

module fifo_push_ctl
	import fifo_ctl_pkg::*;
(
	input  wire logic        rclk,
	input  wire logic        rst_n,
	input  wire fifo_cfg_t   cfg,
	input  wire logic        wen,
	input  wire ptr_t        rptr,
	output ptr_t             wptr,
	output push_flags_t      flags
);

	// ====================
	// Configuration decode
	// ====================

	logic                 wr_on;
	logic [PTR_WIDTH:0]   cap;
	logic [PTR_WIDTH+1:0] cap_w;
	logic [PTR_WIDTH+1:0] step_w;
	logic [PTR_WIDTH+1:0] paf_lvl;
	ptr_t                 step_p;

	assign wr_on = (cfg.width != OFF);
	assign cap = capacity_bytes(cfg.depth);
	assign cap_w = {1'b0, cap};

	// Step in bytes, widened for the flag compares.
	assign step_w = {{(PTR_WIDTH - 1){1'b0}}, step_bytes(cfg.width)};
	assign step_p = step_w[PTR_WIDTH-1:0];

	// Almost-full level in bytes.
	assign paf_lvl = {{(PTR_WIDTH + 2 - ADDR_WIDTH){1'b0}}, cfg.upaf} * step_w;

	// ====================
	// Write pointer
	// ====================

	logic wr_ok;
	ptr_t wptr_nx;

	// A write while full is refused.
	assign wr_ok = wen & wr_on & ~flags.full;
	assign wptr_nx = wr_ok ? wptr + step_p : wptr;

	// ====================
	// Occupancy
	// ====================

	ptr_t                 used_p;
	logic [PTR_WIDTH+1:0] used_nx;
	logic [PTR_WIDTH+1:0] free_nx;

	// Wraps modulo 2^PTR_WIDTH, so the difference is the byte count.
	assign used_p = wptr_nx - rptr;
	assign used_nx = {2'b00, used_p};
	assign free_nx = cap_w - used_nx;

	// ====================
	// Flags
	// ====================

	push_flags_t flags_nx;

	always_comb begin
		flags_nx = '0;
		if (wr_on) begin
			flags_nx.full = (free_nx < step_w);
			flags_nx.fmo = (free_nx == step_w);
			flags_nx.paf = (free_nx < paf_lvl);
			// Sampled only on edges with wen high.
			flags_nx.overflow = wen ? flags.full : flags.overflow;
		end
	end

	// ====================
	// Registers
	// ====================

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
		end else begin
			wptr <= wptr_nx;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			flags <= flags_nx;
		end
	end

endmodule

`default_nettype wire

// File: fifo_pop_ctl.sv
// Pop side; cfg may change only in reset, and wptr must be the push-side register output.
`timescale 1ns/1ps
`default_nettype none

module fifo_pop_ctl
	import fifo_ctl_pkg::*;
(
	input  wire logic        rclk,
	input  wire logic        rst_n,
	input  wire fifo_cfg_t   cfg,
	input  wire logic        ren,
	input  wire ptr_t        wptr,
	output ptr_t             rptr,
	output pop_flags_t       flags
);

	// ====================
	// Configuration decode
	// ====================

	logic                 rd_on;
	logic [PTR_WIDTH+1:0] step_w;
	logic [PTR_WIDTH+1:0] pae_lvl;
	ptr_t                 step_p;

	assign rd_on = (cfg.width != OFF);

	// Step in bytes, widened for the flag compares.
	assign step_w = {{(PTR_WIDTH - 1){1'b0}}, step_bytes(cfg.width)};
	assign step_p = step_w[PTR_WIDTH-1:0];

	// Almost-empty level, scaled by the step like the almost-full one.
	assign pae_lvl = {{(PTR_WIDTH + 2 - ADDR_WIDTH){1'b0}}, cfg.upae} * step_w;

	// ====================
	// Read pointer
	// ====================

	logic rd_ok;
	ptr_t rptr_nx;

	// A read while empty is refused.
	assign rd_ok = ren & rd_on & ~flags.empty;
	assign rptr_nx = rd_ok ? rptr + step_p : rptr;

	// ====================
	// Occupancy
	// ====================

	ptr_t                 used_p;
	logic [PTR_WIDTH+1:0] used_nx;

	// Write pointer arrives one cycle after the push side moved it.
	assign used_p = wptr - rptr_nx;
	assign used_nx = {2'b00, used_p};

	// ====================
	// Flags
	// ====================

	pop_flags_t flags_nx;

	always_comb begin
		if (rd_on) begin
			flags_nx.empty = (used_nx < step_w);
			flags_nx.epo = (used_nx == step_w);
			flags_nx.pae = (used_nx < pae_lvl);
			// Sampled only on edges with ren high.
			flags_nx.underflow = ren ? flags.empty : flags.underflow;
		end else begin
			// Disabled FIFO reads as drained
			flags_nx.empty = 1'b1;
			flags_nx.epo = 1'b0;
			flags_nx.pae = 1'b1;
			flags_nx.underflow = 1'b0;
		end
	end

	// ====================
	// Registers
	// ====================

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			rptr <= '0;
		end else begin
			rptr <= rptr_nx;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			flags.empty <= 1'b1;
			flags.epo <= 1'b0;
			flags.pae <= 1'b1;
			flags.underflow <= 1'b0;
		end else begin
			flags <= flags_nx;
		end
	end

endmodule

`default_nettype wire

// File: fifo_ctl.sv
// FIFO control top; the RAM decodes only the low log2(capacity) bits of waddr and raddr.
`timescale 1ns/1ps
`default_nettype none

module fifo_ctl
	import fifo_ctl_pkg::*;
(
	input  wire logic        rclk,
	input  wire logic        rst_n,
	input  wire fifo_cfg_t   cfg,
	input  wire logic        wen,
	input  wire logic        ren,
	output addr_t            waddr,
	output addr_t            raddr,
	output push_flags_t      push_flags,
	output pop_flags_t       pop_flags
);

	// ====================
	// Pointer exchange
	// ====================

	// Both are register outputs, so each side sees the other a cycle late.
	ptr_t wptr;
	ptr_t rptr;

	fifo_push_ctl u_push (
		.rclk  (rclk),
		.rst_n (rst_n),
		.cfg   (cfg),
		.wen   (wen),
		.rptr  (rptr),
		.wptr  (wptr),
		.flags (push_flags)
	);

	fifo_pop_ctl u_pop (
		.rclk  (rclk),
		.rst_n (rst_n),
		.cfg   (cfg),
		.ren   (ren),
		.wptr  (wptr),
		.rptr  (rptr),
		.flags (pop_flags)
	);

	// ====================
	// RAM addresses
	// ====================

	// Wrap bit dropped.
	assign waddr = wptr[ADDR_WIDTH-1:0];
	assign raddr = rptr[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// File: fifo_ctl_checker.sv
// Port-level assertions for fifo_ctl; they hold only while cfg stays fixed outside reset.
`timescale 1ns/1ps
`default_nettype none

module fifo_ctl_checker
	import fifo_ctl_pkg::*;
(
	input wire logic        rclk,
	input wire logic        rst_n,
	input wire addr_t       waddr,
	input wire addr_t       raddr,
	input wire push_flags_t push_flags,
	input wire pop_flags_t  pop_flags
);

	int fail_count = 0;

	// ====================
	// Flag consistency
	// ====================

	a_full_empty_excl: assert property (@(posedge rclk) disable iff (!rst_n)
		!(push_flags.full && pop_flags.empty))
	else begin
		$error("full and empty are both high");
		fail_count++;
	end

	a_fmo_not_full: assert property (@(posedge rclk) disable iff (!rst_n)
		push_flags.fmo |-> !push_flags.full)
	else begin
		$error("fmo is high together with full");
		fail_count++;
	end

	a_epo_not_empty: assert property (@(posedge rclk) disable iff (!rst_n)
		pop_flags.epo |-> !pop_flags.empty)
	else begin
		$error("epo is high together with empty");
		fail_count++;
	end

	// ====================
	// Refused accesses
	// ====================

	// A refused write or read leaves its address alone.
	a_waddr_hold: assert property (@(posedge rclk) disable iff (!rst_n)
		push_flags.full |=> $stable(waddr))
	else begin
		$error("waddr moved while full");
		fail_count++;
	end

	a_raddr_hold: assert property (@(posedge rclk) disable iff (!rst_n)
		pop_flags.empty |=> $stable(raddr))
	else begin
		$error("raddr moved while empty");
		fail_count++;
	end

endmodule

bind fifo_ctl fifo_ctl_checker u_checker (
	.rclk       (rclk),
	.rst_n      (rst_n),
	.waddr      (waddr),
	.raddr      (raddr),
	.push_flags (push_flags),
	.pop_flags  (pop_flags)
);

`default_nettype wire

// File: tb_fifo_ctl.sv
// Single-clock testbench with an occupancy model; it uses depth codes 0 to 6 only.
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_ctl
	import fifo_ctl_pkg::*;
;

	logic        rclk;
	logic        rst_n;
	fifo_cfg_t   cfg;
	logic        wen;
	logic        ren;
	addr_t       waddr;
	addr_t       raddr;
	push_flags_t push_flags;
	pop_flags_t  pop_flags;

	int errors;
	int timeouts;
	int n;

	// Model state.
	int          m_wp;
	int          m_rp;
	push_flags_t m_push;
	pop_flags_t  m_pop;

	fifo_ctl uut (
		.rclk       (rclk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.wen        (wen),
		.ren        (ren),
		.waddr      (waddr),
		.raddr      (raddr),
		.push_flags (push_flags),
		.pop_flags  (pop_flags)
	);

	initial begin
		rclk = 1'b0;
		forever #10 rclk = ~rclk;
	end

	// ====================
	// Reference model
	// ====================

	function automatic int bytes_for_depth(input logic [2:0] code);
		if (code == 3'd7) begin
			return 4096;
		end
		return 2048 >> code;
	endfunction

	function automatic int bytes_per_access(input width_mode_t mode);
		case (mode)
			W32:     return 4;
			W16:     return 2;
			W8:      return 1;
			default: return 0;
		endcase
	endfunction

	function automatic int wrap_ptr(input int v);
		return v & ((1 << PTR_WIDTH) - 1);
	endfunction

	// One rising edge; each side sees the other's old pointer.
	task automatic model_edge();
		int          cap;
		int          step;
		int          used;
		int          free;
		int          wp_nx;
		int          rp_nx;
		bit          on;
		push_flags_t nxt_push;
		pop_flags_t  nxt_pop;
		if (!rst_n) begin
			m_wp = 0;
			m_rp = 0;
			m_push = '0;
			m_pop = '0;
			m_pop.empty = 1'b1;
			m_pop.pae = 1'b1;
		end else begin
			on = (cfg.width != OFF);
			step = bytes_per_access(cfg.width);
			cap = bytes_for_depth(cfg.depth);
			wp_nx = m_wp;
			rp_nx = m_rp;
			if (wen && on && !m_push.full) wp_nx = wrap_ptr(m_wp + step);
			if (ren && on && !m_pop.empty) rp_nx = wrap_ptr(m_rp + step);
			used = wrap_ptr(wp_nx - m_rp);
			free = cap - used;
			nxt_push = '0;
			nxt_pop = '0;
			nxt_pop.empty = 1'b1;
			nxt_pop.pae = 1'b1;
			if (on) begin
				nxt_push.full = (free < step);
				nxt_push.fmo = (free == step);
				nxt_push.paf = (free < int'(cfg.upaf) * step);
				nxt_push.overflow = wen ? m_push.full : m_push.overflow;
				used = wrap_ptr(m_wp - rp_nx);
				nxt_pop.empty = (used < step);
				nxt_pop.epo = (used == step);
				nxt_pop.pae = (used < int'(cfg.upae) * step);
				nxt_pop.underflow = ren ? m_pop.empty : m_pop.underflow;
			end
			m_push = nxt_push;
			m_pop = nxt_pop;
			m_wp = wp_nx;
			m_rp = rp_nx;
		end
	endtask

	// ====================
	// Checks
	// ====================

	task automatic expect_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("mismatch time=%0t %s expected %0b actual %0b", $time, name, exp, act);
		end
	endtask

	task automatic expect_value(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("mismatch time=%0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic compare_outputs();
		expect_value("waddr", int'(m_wp[ADDR_WIDTH-1:0]), int'(waddr));
		expect_value("raddr", int'(m_rp[ADDR_WIDTH-1:0]), int'(raddr));
		expect_bit("push_flags.full", m_push.full, push_flags.full);
		expect_bit("push_flags.fmo", m_push.fmo, push_flags.fmo);
		expect_bit("push_flags.paf", m_push.paf, push_flags.paf);
		expect_bit("push_flags.overflow", m_push.overflow, push_flags.overflow);
		expect_bit("pop_flags.empty", m_pop.empty, pop_flags.empty);
		expect_bit("pop_flags.epo", m_pop.epo, pop_flags.epo);
		expect_bit("pop_flags.pae", m_pop.pae, pop_flags.pae);
		expect_bit("pop_flags.underflow", m_pop.underflow, pop_flags.underflow);
	endtask

	// ====================
	// Stimulus helpers
	// ====================

	// Outputs are compared 1 ns after the edge, then new inputs may follow.
	task automatic tick();
		@(posedge rclk);
		model_edge();
		#1;
		compare_outputs();
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) tick();
	endtask

	task automatic apply_reset(input logic [2:0] depth, input width_mode_t mode,
		input addr_t upaf, input addr_t upae);
		rst_n = 1'b0;
		wen = 1'b0;
		ren = 1'b0;
		cfg.depth = depth;
		cfg.width = mode;
		cfg.upaf = upaf;
		cfg.upae = upae;
		repeat (16) tick();
		rst_n = 1'b1;
		tick();
	endtask

	task automatic fill_to_full(input int limit, output int writes);
		writes = 0;
		wen = 1'b1;
		while (!push_flags.full && writes < limit) begin
			tick();
			writes++;
		end
		wen = 1'b0;
		if (!push_flags.full) begin
			timeouts++;
			$display("timed out waiting for full to rise");
		end
	endtask

	task automatic drain_to_empty(input int limit, output int reads);
		reads = 0;
		ren = 1'b1;
		while (!pop_flags.empty && reads < limit) begin
			tick();
			reads++;
		end
		ren = 1'b0;
		if (!pop_flags.empty) begin
			timeouts++;
			$display("timed out waiting for empty to rise");
		end
	endtask

	task automatic wait_push_room(input int limit);
		int k;
		k = 0;
		while (push_flags.full && k < limit) begin
			tick();
			k++;
		end
		if (push_flags.full) begin
			timeouts++;
			$display("timed out waiting for full to fall");
		end
	endtask

	task automatic random_traffic(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			// Lean toward writes first, then toward reads.
			if (i < cycles / 2) begin
				wen = ($urandom % 100) < 70;
				ren = ($urandom % 100) < 35;
			end else begin
				wen = ($urandom % 100) < 35;
				ren = ($urandom % 100) < 70;
			end
			tick();
		end
		wen = 1'b0;
		ren = 1'b0;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		void'($urandom(37506));
		errors = 0;
		timeouts = 0;
		rst_n = 1'b0;
		wen = 1'b0;
		ren = 1'b0;
		cfg = '0;

		// Byte mode, 32 bytes, thresholds 4 and 3.
		apply_reset(3'd6, W8, 11'd4, 11'd3);
		idle(2);
		fill_to_full(40, n);
		expect_value("writes until full", 32, n);
		wen = 1'b1;
		tick();
		wen = 1'b0;
		tick();
		ren = 1'b1;
		tick();
		ren = 1'b0;
		wait_push_room(8);
		wen = 1'b1;
		tick();
		wen = 1'b0;
		idle(2);
		drain_to_empty(40, n);
		expect_value("reads until empty", 32, n);
		ren = 1'b1;
		tick();
		ren = 1'b0;
		idle(2);

		// Word mode holds eight words at depth code 6.
		apply_reset(3'd6, W32, 11'd4, 11'd3);
		fill_to_full(16, n);
		expect_value("words until full", 8, n);
		idle(2);
		drain_to_empty(16, n);
		expect_value("words until empty", 8, n);
		idle(2);

		// Disabled FIFO ignores both strobes.
		apply_reset(3'd6, OFF, 11'd4, 11'd3);
		wen = 1'b1;
		ren = 1'b1;
		idle(10);
		wen = 1'b0;
		ren = 1'b0;

		apply_reset(3'd5, W16, 11'd4, 11'd3);
		random_traffic(400);
		idle(4);

		$display("error counts: model %0d, timeouts %0d, assertions %0d",
			errors, timeouts, uut.u_checker.fail_count);
		if (errors == 0 && timeouts == 0 && uut.u_checker.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
fifo_ctl_pkg.sv
fifo_push_ctl.sv
fifo_pop_ctl.sv
fifo_ctl.sv
fifo_ctl_checker.sv
tb_fifo_ctl.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the FIFO control testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_fifo_ctl -f flist.f -o sim \
	&& ./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
